/* testbench/issue_stimulus.txt */
// Record count, then one micro-op per line, all hex, ex_type 0 is ALU and 1 is LSU
// wid ex_type op wb rd rs1 src2 use_imm rs1_data rs2_data
1c
0 0 1 1 01 00 0005 1 00000000 00000005
0 0 1 1 02 01 0003 1 00000005 00000003
0 0 0 1 03 02 0001 0 00000008 00000005
0 0 1 1 01 03 ffff 1 0000000d ffffffff
0 1 8 1 04 01 0003 0 0000000c 0000000d
0 0 1 1 05 04 0020 1 ffffffe6 00000020
1 1 8 1 01 00 7fff 1 00000000 00007fff
1 0 1 1 02 01 8000 1 ffff8000 ffff8000
2 0 1 1 00 00 1234 1 00000000 00001234
2 0 1 1 01 00 0011 1 00000000 00000011
2 0 0 1 02 01 0000 0 00000011 00000000
2 1 8 1 03 00 0002 0 00000000 00000011
2 0 2 0 07 03 0000 0 ffffffee 00000000
2 0 1 1 04 07 0001 1 00000000 00000001
3 1 8 1 0a 00 00ff 1 00000000 000000ff
3 1 9 1 0b 0a 000a 0 ffffff00 ffffff00
3 0 2 0 00 0b fff0 1 000001ff fffffff0
1 0 0 1 03 02 0001 0 ffff0000 ffff8000
0 0 0 1 06 05 0004 0 00000006 ffffffe6
3 0 1 1 01 0b 0001 1 000001ff 00000001
1 1 8 1 04 03 0000 1 fffe8000 00000000
2 0 0 1 05 04 0003 0 00000001 ffffffee
0 1 a 0 00 06 0001 0 ffffffec 0000000c
3 0 0 1 02 01 000a 0 00000200 ffffff00
1 0 1 1 00 04 0002 1 00017fff 00000002
1 0 0 1 05 00 0004 0 00000000 00017fff
3 1 8 1 03 02 0000 0 00000100 00000000
0 0 1 1 07 06 8001 1 ffffffec ffff8001

/* tb.f */
verilog/isa_pkg.sv
verilog/issue_pkg.sv
verilog/issue_ibuffer.sv
verilog/issue_scoreboard.sv
verilog/issue_operands.sv
verilog/issue_dispatch.sv
verilog/issue_stage.sv
testbench/clock_gen.sv
testbench/issue_tb.sv

/* Makefile */
SIM      = verilator
TOP      = issue_tb
FILELIST = tb.f
FLAGS    = --binary --timing -j 0 --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/issue_tb.sv */
// Issue stage testbench
`timescale 1ns/1ps

module issue_tb import isa_pkg::*, issue_pkg::*; ();

    localparam int rec_fields = 10;
    localparam int max_records = 64;
    localparam int reset_cycles = 4;
    localparam int drive_delay = 1;

    logic                     clk;
    logic                     reset;
    logic                     decode_valid;
    logic                     decode_ready;
    uop_t                     decode_data;
    logic                     wb_valid;
    writeback_t               wb_data;
    logic                     alu_valid;
    logic                     alu_ready;
    operands_t                alu_data;
    logic                     lsu_valid;
    logic                     lsu_ready;
    operands_t                lsu_data;
    logic [perf_ctr_bits-1:0] decode_stalls;

    // Count word first, then ten fields per record
    word_t      stim_mem [0:max_records*rec_fields];
    operands_t  records [max_records];
    operands_t  exp_q [num_warps][$];
    writeback_t wb_pend [$];
    int         wb_due [$];
    int         num_records = 0;
    int         dispatch_count = 0;
    int         cycle = 0;
    int         timeout_limit = 0;
    integer     seed = 32'h4eb8e043;

    clock_gen i_clock_gen (
        .clk (clk)
    );

    issue_stage i_issue_stage (
        .clk           (clk),
        .reset         (reset),
        .decode_valid  (decode_valid),
        .decode_ready  (decode_ready),
        .decode_data   (decode_data),
        .wb_valid      (wb_valid),
        .wb_data       (wb_data),
        .alu_valid     (alu_valid),
        .alu_ready     (alu_ready),
        .alu_data      (alu_data),
        .lsu_valid     (lsu_valid),
        .lsu_ready     (lsu_ready),
        .lsu_data      (lsu_data),
        .decode_stalls (decode_stalls)
    );

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(string name, word_t expected, word_t actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s: expected 0x%h, actual 0x%h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic load_stimulus();
        int base;
        $readmemh("testbench/issue_stimulus.txt", stim_mem);
        num_records = int'(stim_mem[0]);
        assert (num_records > 0 && num_records <= max_records) else begin
            $display("Stimulus file gives an unusable record count of %0d", num_records);
            fail_run();
        end
        for (int i = 0; i < num_records; i++) begin
            base = 1 + i * rec_fields;
            records[i] = '0;
            records[i].uop.wid = wid_t'(stim_mem[base]);
            records[i].uop.ex_type = ex_type_t'(stim_mem[base + 1][0]);
            records[i].uop.op = op_t'(stim_mem[base + 2]);
            records[i].uop.wb = stim_mem[base + 3][0];
            records[i].uop.rd = reg_idx_t'(stim_mem[base + 4]);
            records[i].uop.rs1 = reg_idx_t'(stim_mem[base + 5]);
            records[i].uop.src2.imm = stim_mem[base + 6][15:0];
            records[i].uop.use_imm = stim_mem[base + 7][0];
            records[i].rs1_data = stim_mem[base + 8];
            records[i].rs2_data = stim_mem[base + 9];
            exp_q[records[i].uop.wid].push_back(records[i]);
        end
        timeout_limit = 40 * num_records + 100;
    endtask

    // Feed the decode port in file order, holding each micro-op until accepted
    task automatic drive_decode();
        logic accepted;
        for (int i = 0; i < num_records; i++) begin
            decode_valid = 1'b1;
            decode_data = records[i].uop;
            do begin
                @(negedge clk);
                accepted = decode_ready;
                @(posedge clk);
                #drive_delay;
            end while (!accepted);
        end
        decode_valid = 1'b0;
        decode_data = '0;
    endtask

    task automatic check_dispatch(operands_t got, logic on_lsu);
        operands_t  exp;
        wid_t       w;
        word_t      sum;
        writeback_t result;
        w = got.uop.wid;
        assert (exp_q[w].size() > 0) else begin
            $display("Warp %0d dispatched a micro-op with no record left to match", w);
            fail_run();
        end
        exp = exp_q[w].pop_front();
        compare_value("lsu_valid", word_t'(exp.uop.ex_type == ex_lsu), word_t'(on_lsu));
        compare_value("uop.wid", word_t'(exp.uop.wid), word_t'(got.uop.wid));
        compare_value("uop.ex_type", word_t'(exp.uop.ex_type), word_t'(got.uop.ex_type));
        compare_value("uop.op", word_t'(exp.uop.op), word_t'(got.uop.op));
        compare_value("uop.wb", word_t'(exp.uop.wb), word_t'(got.uop.wb));
        compare_value("uop.rd", word_t'(exp.uop.rd), word_t'(got.uop.rd));
        compare_value("uop.rs1", word_t'(exp.uop.rs1), word_t'(got.uop.rs1));
        compare_value("uop.src2", word_t'(exp.uop.src2), word_t'(got.uop.src2));
        compare_value("uop.use_imm", word_t'(exp.uop.use_imm), word_t'(got.uop.use_imm));
        compare_value("rs1_data", exp.rs1_data, got.rs1_data);
        compare_value("rs2_data", exp.rs2_data, got.rs2_data);
        dispatch_count++;
        // The ALU adds its sources and the LSU returns the inverted sum
        if (exp.uop.wb) begin
            sum = exp.rs1_data + exp.rs2_data;
            result.wid = exp.uop.wid;
            result.rd = exp.uop.rd;
            result.data = (exp.uop.ex_type == ex_lsu) ? ~sum : sum;
            wb_pend.push_back(result);
            wb_due.push_back(cycle + 2 + int'($unsigned($random(seed)) % 4));
        end
    endtask

    task automatic check_ports();
        assert (!(alu_valid && lsu_valid)) else begin
            $display("ALU and LSU valids were high in the same cycle");
            fail_run();
        end
        if (alu_valid && alu_ready) begin
            check_dispatch(alu_data, 1'b0);
        end else if (lsu_valid && lsu_ready) begin
            check_dispatch(lsu_data, 1'b1);
        end
    endtask

    // Random unit readiness and one writeback per cycle, oldest due first
    task automatic drive_units();
        int pick;
        alu_ready = ($random(seed) & 3) != 0;
        lsu_ready = ($random(seed) & 3) != 0;
        pick = -1;
        for (int k = 0; k < wb_due.size(); k++) begin
            if (pick < 0 && wb_due[k] <= cycle) begin
                pick = k;
            end
        end
        if (pick >= 0) begin
            wb_valid = 1'b1;
            wb_data = wb_pend[pick];
            wb_pend.delete(pick);
            wb_due.delete(pick);
        end else begin
            wb_valid = 1'b0;
            wb_data = '0;
        end
    endtask

    initial begin
        alu_ready = 1'b0;
        lsu_ready = 1'b0;
        wb_valid = 1'b0;
        wb_data = '0;
        forever begin
            @(posedge clk);
            #drive_delay;
            drive_units();
        end
    end

    // Outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        if (!reset) begin
            check_ports();
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle = cycle + 1;
            assert (cycle <= timeout_limit) else begin
                $display("Timeout after %0d cycles with %0d of %0d micro-ops dispatched",
                         cycle, dispatch_count, num_records);
                fail_run();
            end
        end
    end

    initial begin
        reset = 1'b1;
        decode_valid = 1'b0;
        decode_data = '0;
        load_stimulus();
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        drive_decode();
        while (dispatch_count < num_records) begin
            @(posedge clk);
        end
        // Extra cycles let a duplicated dispatch show up
        repeat (10) @(posedge clk);
        assert (decode_stalls != '0) else begin
            $display("Decode stall counter stayed at zero after the single-warp burst");
            fail_run();
        end
        if (dispatch_count == num_records) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("Dispatched %0d micro-ops instead of %0d", dispatch_count, num_records);
            fail_run();
        end
    end

endmodule

/* testbench/clock_gen.sv */
// Testbench clock source
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    // Half of the 4 ns period
    localparam int half_period = 2;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period;
            clk = ~clk;
        end
    end

endmodule

/* verilog/issue_stage.sv */
// SIMT issue stage top level
`timescale 1ns/1ps

module issue_stage import issue_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      decode_valid,
    output logic                      decode_ready,
    input  uop_t                      decode_data,
    input  logic                      wb_valid,
    input  writeback_t                wb_data,
    output logic                      alu_valid,
    input  logic                      alu_ready,
    output operands_t                 alu_data,
    output logic                      lsu_valid,
    input  logic                      lsu_ready,
    output operands_t                 lsu_data,
    output logic [perf_ctr_bits-1:0]  decode_stalls
);

    logic [num_warps-1:0] head_valid;
    uop_t [num_warps-1:0] head_data;
    wid_t                 rr_wid;
    logic                 ibuf_pick_valid;
    wid_t                 ibuf_pick;
    logic                 sb_valid;
    logic                 sb_ready;
    uop_t                 sb_data;
    logic                 opd_valid;
    logic                 opd_ready;
    operands_t            opd_data;

    issue_ibuffer i_ibuffer (
        .clk             (clk),
        .reset           (reset),
        .decode_valid    (decode_valid),
        .decode_data     (decode_data),
        .ibuf_pick_valid (ibuf_pick_valid),
        .ibuf_pick       (ibuf_pick),
        .decode_ready    (decode_ready),
        .head_valid      (head_valid),
        .head_data       (head_data),
        .rr_wid          (rr_wid),
        .decode_stalls   (decode_stalls)
    );

    issue_scoreboard i_scoreboard (
        .clk             (clk),
        .reset           (reset),
        .head_valid      (head_valid),
        .head_data       (head_data),
        .rr_wid          (rr_wid),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data),
        .sb_ready        (sb_ready),
        .ibuf_pick_valid (ibuf_pick_valid),
        .ibuf_pick       (ibuf_pick),
        .sb_valid        (sb_valid),
        .sb_data         (sb_data)
    );

    issue_operands i_operands (
        .clk       (clk),
        .reset     (reset),
        .sb_valid  (sb_valid),
        .sb_data   (sb_data),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .opd_ready (opd_ready),
        .sb_ready  (sb_ready),
        .opd_valid (opd_valid),
        .opd_data  (opd_data)
    );

    issue_dispatch i_dispatch (
        .clk       (clk),
        .reset     (reset),
        .opd_valid (opd_valid),
        .opd_data  (opd_data),
        .alu_ready (alu_ready),
        .lsu_ready (lsu_ready),
        .opd_ready (opd_ready),
        .alu_valid (alu_valid),
        .alu_data  (alu_data),
        .lsu_valid (lsu_valid),
        .lsu_data  (lsu_data)
    );

endmodule

/* verilog/issue_dispatch.sv */
// Dispatch to execution units
`timescale 1ns/1ps

module issue_dispatch import isa_pkg::*, issue_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       opd_valid,
    input  operands_t  opd_data,
    input  logic       alu_ready,
    input  logic       lsu_ready,
    output logic       opd_ready,
    output logic       alu_valid,
    output operands_t  alu_data,
    output logic       lsu_valid,
    output operands_t  lsu_data
);

    logic      out_valid;
    operands_t out_data;
    logic      unit_ready;

    // Only the unit named by ex_type can drain the register
    assign unit_ready = (out_data.uop.ex_type == ex_lsu) ? lsu_ready : alu_ready;
    assign opd_ready = !out_valid || unit_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (opd_ready) begin
            out_valid <= opd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (opd_valid && opd_ready) begin
            out_data <= opd_data;
        end
    end

    assign alu_valid = out_valid && (out_data.uop.ex_type == ex_alu);
    assign lsu_valid = out_valid && (out_data.uop.ex_type == ex_lsu);

    // Both ports share the payload and are told apart by their valids
    assign alu_data = out_data;
    assign lsu_data = out_data;

endmodule

/* verilog/issue_operands.sv */
// Operand read stage
`timescale 1ns/1ps

module issue_operands import isa_pkg::*, issue_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        sb_valid,
    input  uop_t        sb_data,
    input  logic        wb_valid,
    input  writeback_t  wb_data,
    input  logic        opd_ready,
    output logic        sb_ready,
    output logic        opd_valid,
    output operands_t   opd_data
);

    word_t rf [num_warps][num_regs];
    logic  load;
    word_t rs1_val;
    word_t rs2_val;

    // Register 0 reads as zero whatever was written to it
    function automatic word_t read_reg(wid_t wid, reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        return rf[wid][idx];
    endfunction

    function automatic word_t sext_imm(logic [src2_bits-1:0] imm);
        return {{(xlen - src2_bits){imm[src2_bits-1]}}, imm};
    endfunction

    // Writebacks land on the same edge that clears their scoreboard bit
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps; w++) begin
                for (int r = 0; r < num_regs; r++) begin
                    rf[w][r] <= '0;
                end
            end
        end else if (wb_valid) begin
            rf[wb_data.wid][wb_data.rd] <= wb_data.data;
        end
    end

    assign sb_ready = !opd_valid || opd_ready;
    assign load = sb_valid && sb_ready;

    always_comb begin
        rs1_val = read_reg(sb_data.wid, sb_data.rs1);
        if (sb_data.use_imm) begin
            rs2_val = sext_imm(sb_data.src2.imm);
        end else begin
            rs2_val = read_reg(sb_data.wid, sb_data.src2.r.rs2);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opd_valid <= 1'b0;
        end else if (sb_ready) begin
            opd_valid <= sb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            opd_data.uop <= sb_data;
            opd_data.rs1_data <= rs1_val;
            opd_data.rs2_data <= rs2_val;
        end
    end

endmodule

/* verilog/issue_scoreboard.sv */
// Pending-write scoreboard
`timescale 1ns/1ps

module issue_scoreboard import isa_pkg::*, issue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [num_warps-1:0]  head_valid,
    input  uop_t [num_warps-1:0]  head_data,
    input  wid_t                  rr_wid,
    input  logic                  wb_valid,
    input  writeback_t            wb_data,
    input  logic                  sb_ready,
    output logic                  ibuf_pick_valid,
    output wid_t                  ibuf_pick,
    output logic                  sb_valid,
    output uop_t                  sb_data
);

    // One bit per warp and register, set while a write is in flight
    logic [num_warps-1:0][num_regs-1:0] pending;
    logic [num_warps-1:0]               warp_ok;
    logic                               found;
    wid_t                               sel;
    logic                               load;
    uop_t                               sel_uop;

    // A head may go only when none of its registers has a write pending
    always_comb begin
        for (int w = 0; w < num_warps; w++) begin
            warp_ok[w] = head_valid[w]
                && !pending[w][head_data[w].rs1]
                && !(!head_data[w].use_imm && pending[w][head_data[w].src2.r.rs2])
                && !pending[w][head_data[w].rd];
        end
    end

    // First hazard-free warp, searching upward from the round-robin pointer
    always_comb begin
        wid_t cand;
        found = 1'b0;
        sel = rr_wid;
        for (int i = 0; i < num_warps; i++) begin
            cand = wid_t'((int'(rr_wid) + i) % num_warps);
            if (!found && warp_ok[cand]) begin
                found = 1'b1;
                sel = cand;
            end
        end
    end

    assign sel_uop = head_data[sel];

    // The output register takes a new head when empty or draining this cycle
    assign load = found && (!sb_valid || sb_ready);

    assign ibuf_pick_valid = load;
    assign ibuf_pick = sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_data.wid][wb_data.rd] <= 1'b0;
            end
            // Register 0 is hard-wired, so it never gets a mark
            if (load && sel_uop.wb && (sel_uop.rd != '0)) begin
                pending[sel][sel_uop.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sb_valid <= 1'b0;
        end else if (!sb_valid || sb_ready) begin
            sb_valid <= found;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sb_data <= sel_uop;
        end
    end

endmodule

/* verilog/issue_ibuffer.sv */
// Per-warp instruction buffer
`timescale 1ns/1ps

module issue_ibuffer import issue_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      decode_valid,
    input  uop_t                      decode_data,
    input  logic                      ibuf_pick_valid,
    input  wid_t                      ibuf_pick,
    output logic                      decode_ready,
    output logic [num_warps-1:0]      head_valid,
    output uop_t [num_warps-1:0]      head_data,
    output wid_t                      rr_wid,
    output logic [perf_ctr_bits-1:0]  decode_stalls
);

    uop_t                 mem [num_warps][ibuf_depth];
    ibuf_ptr_t            rd_ptr [num_warps];
    ibuf_ptr_t            wr_ptr [num_warps];
    ibuf_cnt_t            count [num_warps];
    logic [num_warps-1:0] push;
    logic [num_warps-1:0] pop;

    // Decode only stalls when the target warp's FIFO is full
    assign decode_ready = (count[decode_data.wid] != ibuf_cnt_t'(ibuf_depth));

    always_comb begin
        for (int w = 0; w < num_warps; w++) begin
            push[w] = decode_valid && decode_ready && (decode_data.wid == wid_t'(w));
            pop[w] = ibuf_pick_valid && (ibuf_pick == wid_t'(w));
            head_valid[w] = (count[w] != '0);
            head_data[w] = mem[w][rd_ptr[w]];
        end
    end

    always_ff @(posedge clk) begin
        if (decode_valid && decode_ready) begin
            mem[decode_data.wid][wr_ptr[decode_data.wid]] <= decode_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps; w++) begin
                rd_ptr[w] <= '0;
                wr_ptr[w] <= '0;
                count[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_warps; w++) begin
                if (push[w]) begin
                    wr_ptr[w] <= wr_ptr[w] + 1'b1;
                end
                if (pop[w]) begin
                    rd_ptr[w] <= rd_ptr[w] + 1'b1;
                end
                if (push[w] && !pop[w]) begin
                    count[w] <= count[w] + 1'b1;
                end else if (pop[w] && !push[w]) begin
                    count[w] <= count[w] - 1'b1;
                end
            end
        end
    end

    // Round-robin start point moves just past the warp that was last issued
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_wid <= '0;
        end else if (ibuf_pick_valid) begin
            rr_wid <= (ibuf_pick == wid_t'(num_warps - 1)) ? '0 : ibuf_pick + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decode_stalls <= '0;
        end else if (decode_valid && !decode_ready) begin
            decode_stalls <= decode_stalls + 1'b1;
        end
    end

endmodule

/* verilog/issue_pkg.sv */
// Issue pipeline definitions

package issue_pkg;

    import isa_pkg::*;

    // Warp configuration
    localparam int num_warps = 4;
    localparam int wid_bits = $clog2(num_warps);

    // Entries per warp in the instruction buffer, kept a power of two
    localparam int ibuf_depth = 4;
    localparam int ibuf_ptr_bits = $clog2(ibuf_depth);

    localparam int perf_ctr_bits = 32;

    typedef logic [wid_bits-1:0] wid_t;
    typedef logic [ibuf_ptr_bits-1:0] ibuf_ptr_t;

    // One extra bit so a full buffer can be told from an empty one
    typedef logic [ibuf_ptr_bits:0] ibuf_cnt_t;

    // Decoded micro-op as it leaves the decoder
    typedef struct packed {
        wid_t     wid;
        ex_type_t ex_type;
        op_t      op;
        logic     wb;
        reg_idx_t rd;
        reg_idx_t rs1;
        src2_u    src2;
        logic     use_imm;
    } uop_t;

    // Micro-op together with its source values
    typedef struct packed {
        uop_t  uop;
        word_t rs1_data;
        word_t rs2_data;
    } operands_t;

    // Result returned by a unit
    typedef struct packed {
        wid_t     wid;
        reg_idx_t rd;
        word_t    data;
    } writeback_t;

endpackage

/* verilog/isa_pkg.sv */
// Instruction level definitions

package isa_pkg;

    // Data path width and architectural registers per warp
    localparam int xlen = 32;
    localparam int num_regs = 32;

    // Width of the second-source field in a micro-op
    localparam int src2_bits = 16;

    typedef logic [4:0] reg_idx_t;
    typedef logic [xlen-1:0] word_t;

    // Execution unit that receives the micro-op
    typedef enum logic {
        ex_alu = 1'b0,
        ex_lsu = 1'b1
    } ex_type_t;

    // Operation code, interpreted only by the units
    typedef logic [3:0] op_t;

    // Register view of the second source
    typedef struct packed {
        logic [src2_bits-$bits(reg_idx_t)-1:0] pad;
        reg_idx_t                               rs2;
    } src2_reg_t;

    // The use_imm bit of the micro-op tells which view is valid
    typedef union packed {
        src2_reg_t                   r;
        logic signed [src2_bits-1:0] imm;
    } src2_u;

endpackage
